// File: logic/csr_file.sv
/*
 * machine CSR file
 * mstatus, mepc, mcause, mestatus and the two id words, with
 * write/set/clear and trap save and restore
 */

`timescale 1ns/1ps
`default_nettype none

module csr_file import sys_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire csr_op_e         csr_op_i,
    input  wire csr_addr_t       csr_addr_i,
    input  wire [xlen-1:0]       csr_wdata_i,
    input  wire                  commit_i,
    input  wire [xlen-1:0]       mepc_i,
    input  wire exp_code_t       exp_code_i,
    input  wire                  save_exp_i,
    input  wire                  restore_exp_i,
    output logic [xlen-1:0]      csr_rdata_o,
    output logic                 csr_illegal_o,
    output logic                 mstatus_ie_o,
    output logic [xlen-1:0]      mepc_o
);

    // state
    logic            mstatus_ie_q;
    logic            mestatus_ie_q;
    logic [xlen-1:0] mepc_q;
    exp_code_t       mcause_q;

    // next state
    logic            mstatus_ie_d;
    logic            mestatus_ie_d;
    logic [xlen-1:0] mepc_d;
    exp_code_t       mcause_d;

    logic            addr_known;
    logic            addr_ro;
    logic            csr_we;
    logic [xlen-1:0] csr_wval;

    ////////////////////
    // read side
    ////////////////////
    always_comb begin
        csr_rdata_o = '0;
        addr_known  = 1'b1;
        addr_ro     = 1'b0;

        case (csr_addr_i)
            csr_mstatus:  csr_rdata_o = {{(xlen-3){1'b0}}, status_rsvd, mstatus_ie_q};
            csr_mepc:     csr_rdata_o = mepc_q;
            // flag goes to the msb, code stays at the bottom
            csr_mcause:   csr_rdata_o = {mcause_q[5], {(xlen-6){1'b0}}, mcause_q[4:0]};
            csr_mestatus: csr_rdata_o = {{(xlen-3){1'b0}}, status_rsvd, mestatus_ie_q};
            csr_mcpuid: begin
                csr_rdata_o = mcpuid_value;
                addr_ro     = 1'b1;
            end
            csr_mimpid: begin
                csr_rdata_o = mimpid_value;
                addr_ro     = 1'b1;
            end
            // unknown address reads zero
            default:      addr_known = 1'b0;
        endcase
    end

    // any access to an unknown address, or a real write to an id word
    assign csr_illegal_o = !addr_known || (addr_ro && (csr_op_i != csr_nop));

    ////////////////////
    // write value
    ////////////////////
    always_comb begin
        case (csr_op_i)
            csr_write: csr_wval = csr_wdata_i;
            csr_set:   csr_wval = csr_rdata_o | csr_wdata_i;
            csr_clear: csr_wval = csr_rdata_o & ~csr_wdata_i;
            default:   csr_wval = csr_rdata_o;
        endcase
    end

    // trap controller holds commit low on any trap
    assign csr_we = commit_i && (csr_op_i != csr_nop);

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        mstatus_ie_d  = mstatus_ie_q;
        mestatus_ie_d = mestatus_ie_q;
        mepc_d        = mepc_q;
        mcause_d      = mcause_q;

        if (csr_we) begin
            case (csr_addr_i)
                csr_mstatus:  mstatus_ie_d  = csr_wval[0];
                csr_mepc:     mepc_d        = csr_wval;
                csr_mcause:   mcause_d      = {csr_wval[xlen-1], csr_wval[4:0]};
                csr_mestatus: mestatus_ie_d = csr_wval[0];
                default:      ;
            endcase
        end

        // trap entry, stash ie and mask further interrupts
        if (save_exp_i) begin
            mcause_d      = exp_code_i;
            mepc_d        = mepc_i;
            mestatus_ie_d = mstatus_ie_q;
            mstatus_ie_d  = 1'b0;
        end

        // mret brings ie back
        if (restore_exp_i) begin
            mstatus_ie_d = mestatus_ie_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_ie_q  <= 1'b0;
            mestatus_ie_q <= 1'b0;
            mepc_q        <= '0;
            mcause_q      <= '0;
        end else begin
            mstatus_ie_q  <= mstatus_ie_d;
            mestatus_ie_q <= mestatus_ie_d;
            mepc_q        <= mepc_d;
            mcause_q      <= mcause_d;
        end
    end

    assign mstatus_ie_o = mstatus_ie_q;
    assign mepc_o       = mepc_q;

endmodule

`default_nettype wire

// File: logic/sys_decode.sv
/*
 * SYSTEM instruction decoder
 * splits a SYSTEM word into a CSR access or an ECALL/MRET strobe
 */

`timescale 1ns/1ps
`default_nettype none

module sys_decode import sys_pkg::*; (
    input  wire             instr_valid_i,
    input  wire sys_instr_u instr_i,
    output csr_op_e         csr_op_o,
    output csr_addr_t       csr_addr_o,
    output logic            csr_operand_sel_imm_o,
    output logic            csr_rd_en_o,
    output logic            is_csr_o,
    output logic            ecall_o,
    output logic            mret_o,
    output logic            illegal_sys_o
);

    logic       is_system;
    logic [2:0] funct3;
    logic       operand_nz;
    logic       priv_clean;

    // only a valid word with the SYSTEM opcode counts
    assign is_system = instr_valid_i && (instr_i.csr.opcode == opcode_system);
    assign funct3    = instr_i.csr.funct3;

    // rs1 index or zimm, both live in the same field
    assign operand_nz = (instr_i.csr.rs1_zimm != 5'd0);

    // ecall and mret carry zero rs1 and rd
    assign priv_clean = (instr_i.priv.rs1 == 5'd0) && (instr_i.priv.rd == 5'd0);

    always_comb begin
        csr_op_o              = csr_nop;
        csr_operand_sel_imm_o = 1'b0;
        is_csr_o              = 1'b0;
        ecall_o               = 1'b0;
        mret_o                = 1'b0;
        illegal_sys_o         = 1'b0;

        if (is_system) begin
            // upper funct3 bit selects the zimm forms
            csr_operand_sel_imm_o = funct3[2];

            case (funct3)
                funct3_priv: begin
                    if (priv_clean && (instr_i.priv.funct12 == funct12_ecall)) begin
                        ecall_o = 1'b1;
                    end else if (priv_clean && (instr_i.priv.funct12 == funct12_mret)) begin
                        mret_o = 1'b1;
                    end else begin
                        illegal_sys_o = 1'b1;
                    end
                end
                funct3_csrrw, funct3_csrrwi: begin
                    is_csr_o = 1'b1;
                    csr_op_o = csr_write;
                end
                // zero operand field makes set/clear a pure read
                funct3_csrrs, funct3_csrrsi: begin
                    is_csr_o = 1'b1;
                    csr_op_o = operand_nz ? csr_set : csr_nop;
                end
                funct3_csrrc, funct3_csrrci: begin
                    is_csr_o = 1'b1;
                    csr_op_o = operand_nz ? csr_clear : csr_nop;
                end
                // funct3 100 is reserved
                default: begin
                    illegal_sys_o = 1'b1;
                end
            endcase
        end
    end

    assign csr_addr_o = instr_i.csr.csr;

    // writeback only when rd is a real register
    assign csr_rd_en_o = is_csr_o && (instr_i.csr.rd != 5'd0);

endmodule

`default_nettype wire

// File: logic/sys_pkg.sv
/*
 * system unit package
 * CSR addresses, operation and cause encodings, constants and the
 * two views of a SYSTEM instruction word
 */

`default_nettype none

package sys_pkg;

    ////////////////////
    // widths and types
    ////////////////////
    localparam int xlen = 32;

    typedef logic [11:0] csr_addr_t;

    // interrupt flag on top, five-bit code below
    typedef logic [5:0] exp_code_t;

    typedef enum logic [1:0] {
        csr_nop   = 2'b00,
        csr_write = 2'b01,
        csr_set   = 2'b10,
        csr_clear = 2'b11
    } csr_op_e;

    ////////////////////
    // csr map
    ////////////////////
    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mcpuid   = 12'hF00;
    localparam csr_addr_t csr_mimpid   = 12'hF01;
    localparam csr_addr_t csr_mestatus = 12'h7C0;

    // read-only ids, rv32i and anonymous source
    localparam logic [xlen-1:0] mcpuid_value = 32'h0000_0100;
    localparam logic [xlen-1:0] mimpid_value = 32'h0000_8000;

    // fixed field above ie in both status words
    localparam logic [1:0] status_rsvd = 2'b11;

    ////////////////////
    // trap encodings
    ////////////////////
    localparam exp_code_t exp_illegal = 6'b0_00010;
    localparam exp_code_t exp_ecall   = 6'b0_01011;
    localparam exp_code_t exp_irq_ext = 6'b1_01011;

    localparam logic [xlen-1:0] trap_vector = 32'h0000_0100;

    ////////////////////
    // instruction fields
    ////////////////////
    localparam logic [6:0] opcode_system = 7'h73;

    localparam logic [2:0] funct3_priv   = 3'b000;
    localparam logic [2:0] funct3_csrrw  = 3'b001;
    localparam logic [2:0] funct3_csrrs  = 3'b010;
    localparam logic [2:0] funct3_csrrc  = 3'b011;
    localparam logic [2:0] funct3_csrrwi = 3'b101;
    localparam logic [2:0] funct3_csrrsi = 3'b110;
    localparam logic [2:0] funct3_csrrci = 3'b111;

    localparam logic [11:0] funct12_ecall = 12'h000;
    localparam logic [11:0] funct12_mret  = 12'h302;

    // csr form, rs1 field doubles as zimm
    typedef struct packed {
        csr_addr_t  csr;
        logic [4:0] rs1_zimm;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } csr_form_t;

    // privileged form, funct12 picks ecall or mret
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } priv_form_t;

    typedef union packed {
        csr_form_t  csr;
        priv_form_t priv;
    } sys_instr_u;

endpackage

`default_nettype wire

// File: logic/system_unit.sv
/*
 * machine-mode system unit
 * SYSTEM decode, CSR file and trap control for an RV32I core
 */

`timescale 1ns/1ps
`default_nettype none

module system_unit import sys_pkg::*; (
    input  wire             clk,
    input  wire             rst_n_i,
    input  wire             instr_valid_i,
    input  wire sys_instr_u instr_i,
    input  wire [xlen-1:0]  pc_i,
    input  wire [xlen-1:0]  rs1_data_i,
    input  wire             irq_i,
    output logic [xlen-1:0] rd_data_o,
    output logic            rd_we_o,
    output logic            redirect_o,
    output logic [xlen-1:0] redirect_pc_o
);

    // decoder
    csr_op_e         csr_op;
    csr_addr_t       csr_addr;
    logic            sel_imm;
    logic            csr_rd_en;
    logic            is_csr;
    logic            ecall;
    logic            mret;
    logic            illegal_sys;

    // csr file
    logic [xlen-1:0] csr_wdata;
    logic            csr_illegal;
    logic            mstatus_ie;
    logic [xlen-1:0] mepc;

    // trap control
    logic            save_exp;
    logic            restore_exp;
    exp_code_t       exp_code;
    logic            commit;

    sys_decode u_decode (
        .instr_valid_i         (instr_valid_i),
        .instr_i               (instr_i),
        .csr_op_o              (csr_op),
        .csr_addr_o            (csr_addr),
        .csr_operand_sel_imm_o (sel_imm),
        .csr_rd_en_o           (csr_rd_en),
        .is_csr_o              (is_csr),
        .ecall_o               (ecall),
        .mret_o                (mret),
        .illegal_sys_o         (illegal_sys)
    );

    // zimm zero extended, else the register operand
    assign csr_wdata = sel_imm ? {{(xlen-5){1'b0}}, instr_i.csr.rs1_zimm} : rs1_data_i;

    csr_file u_csr (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_op_i      (csr_op),
        .csr_addr_i    (csr_addr),
        .csr_wdata_i   (csr_wdata),
        .commit_i      (commit),
        .mepc_i        (pc_i),
        .exp_code_i    (exp_code),
        .save_exp_i    (save_exp),
        .restore_exp_i (restore_exp),
        .csr_rdata_o   (rd_data_o),
        .csr_illegal_o (csr_illegal),
        .mstatus_ie_o  (mstatus_ie),
        .mepc_o        (mepc)
    );

    trap_ctrl u_trap (
        .instr_valid_i (instr_valid_i),
        .is_csr_i      (is_csr),
        .ecall_i       (ecall),
        .mret_i        (mret),
        .illegal_sys_i (illegal_sys),
        .csr_illegal_i (csr_illegal),
        .irq_i         (irq_i),
        .mstatus_ie_i  (mstatus_ie),
        .mepc_i        (mepc),
        .save_exp_o    (save_exp),
        .restore_exp_o (restore_exp),
        .exp_code_o    (exp_code),
        .commit_o      (commit),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    // no writeback from a trapped instruction
    assign rd_we_o = csr_rd_en && commit;

endmodule

`default_nettype wire

// File: logic/trap_ctrl.sv
/*
 * trap sequencer
 * ranks interrupt, illegal access and ECALL, drives save/restore
 * and the pc redirect
 */

`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import sys_pkg::*; (
    input  wire             instr_valid_i,
    input  wire             is_csr_i,
    input  wire             ecall_i,
    input  wire             mret_i,
    input  wire             illegal_sys_i,
    input  wire             csr_illegal_i,
    input  wire             irq_i,
    input  wire             mstatus_ie_i,
    input  wire [xlen-1:0]  mepc_i,
    output logic            save_exp_o,
    output logic            restore_exp_o,
    output exp_code_t       exp_code_o,
    output logic            commit_o,
    output logic            redirect_o,
    output logic [xlen-1:0] redirect_pc_o
);

    logic irq_take;
    logic illegal_take;
    logic trap;

    ////////////////////
    // trap sources
    ////////////////////

    // interrupt needs a live instruction to replace
    assign irq_take = instr_valid_i && irq_i && mstatus_ie_i;

    // csr illegality only matters for an actual csr instruction,
    // other SYSTEM words also drive the address lines
    assign illegal_take = (is_csr_i && csr_illegal_i) || illegal_sys_i;

    assign trap = irq_take || illegal_take || ecall_i;

    // cause, interrupt first
    always_comb begin
        if (irq_take) begin
            exp_code_o = exp_irq_ext;
        end else if (illegal_take) begin
            exp_code_o = exp_illegal;
        end else begin
            exp_code_o = exp_ecall;
        end
    end

    ////////////////////
    // strobes
    ////////////////////
    assign save_exp_o = trap;

    // an interrupt preempts the mret itself
    assign restore_exp_o = mret_i && !irq_take;

    // csr side effects only when nothing traps
    assign commit_o = is_csr_i && !trap;

    ////////////////////
    // redirect
    ////////////////////
    assign redirect_o    = trap || restore_exp_o;
    assign redirect_pc_o = trap ? trap_vector : mepc_i;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the system unit testbench with Verilator

rm -f sim.log

verilator --binary --timing --assert --top-module tb_system_unit \
    -f system_unit.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; test -f sim.log && ! grep -qF '*** FAILED ***' sim.log \
    || { echo "simulation failed"; exit 1; }

echo "simulation passed"

// File: system_unit.f
logic/sys_pkg.sv
logic/sys_decode.sv
logic/csr_file.sv
logic/trap_ctrl.sv
logic/system_unit.sv
test/tb_system_unit.sv

// File: test/tb_system_unit.sv
/*
 * testbench for the machine-mode system unit
 * directed and random SYSTEM instructions checked against a small
 * model of the machine CSR state
 */

`timescale 1ns/1ps
`default_nettype none

module tb_system_unit import sys_pkg::*; ();

    logic            clk;
    logic            rst_n_i;
    logic            instr_valid_i;
    sys_instr_u      instr_i;
    logic [xlen-1:0] pc_i;
    logic [xlen-1:0] rs1_data_i;
    logic            irq_i;
    logic [xlen-1:0] rd_data_o;
    logic            rd_we_o;
    logic            redirect_o;
    logic [xlen-1:0] redirect_pc_o;

    // model state and its next value
    logic            m_ie;
    logic            m_eie;
    logic [31:0]     m_mepc;
    logic [5:0]      m_cause;
    logic            n_ie;
    logic            n_eie;
    logic [31:0]     n_mepc;
    logic [5:0]      n_cause;

    // expected outputs for the current cycle
    logic            exp_is_csr;
    logic            exp_rd_we;
    logic            exp_redirect;
    logic [31:0]     exp_rd_data;
    logic [31:0]     exp_redirect_pc;

    string           test_name;
    int              errors;
    int              checks;
    int              cycles;
    int              cycle_limit;

    system_unit dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .irq_i         (irq_i),
        .rd_data_o     (rd_data_o),
        .rd_we_o       (rd_we_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic addr_known(input csr_addr_t a);
        return (a == csr_mstatus) || (a == csr_mepc) || (a == csr_mcause) ||
               (a == csr_mestatus) || (a == csr_mcpuid) || (a == csr_mimpid);
    endfunction

    function automatic logic [31:0] model_read(input csr_addr_t a);
        case (a)
            csr_mstatus:  return {29'd0, 2'b11, m_ie};
            csr_mepc:     return m_mepc;
            csr_mcause:   return {m_cause[5], 26'd0, m_cause[4:0]};
            csr_mestatus: return {29'd0, 2'b11, m_eie};
            csr_mcpuid:   return mcpuid_value;
            csr_mimpid:   return mimpid_value;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic compute_expect();
        sys_instr_u  w;
        logic        is_sys;
        logic        is_csr;
        logic        is_ecall;
        logic        is_mret;
        logic        writes;
        logic        bad;
        logic        irq_take;
        logic        trap;
        logic [31:0] operand;
        logic [31:0] old_val;
        logic [31:0] wval;

        w        = instr_i;
        is_sys   = instr_valid_i && (w.csr.opcode == opcode_system);
        is_csr   = is_sys && (w.csr.funct3 != 3'b000) && (w.csr.funct3 != 3'b100);
        is_ecall = is_sys && (w.priv.funct3 == 3'b000) && (w.priv.rs1 == 5'd0) &&
                   (w.priv.rd == 5'd0) && (w.priv.funct12 == 12'h000);
        is_mret  = is_sys && (w.priv.funct3 == 3'b000) && (w.priv.rs1 == 5'd0) &&
                   (w.priv.rd == 5'd0) && (w.priv.funct12 == 12'h302);
        // set/clear with a zero source field is only a read
        writes   = is_csr && ((w.csr.funct3[1:0] == 2'b01) || (w.csr.rs1_zimm != 5'd0));
        bad      = (is_sys && !is_csr && !is_ecall && !is_mret) ||
                   (is_csr && !addr_known(w.csr.csr)) ||
                   (writes && ((w.csr.csr == csr_mcpuid) || (w.csr.csr == csr_mimpid)));
        irq_take = instr_valid_i && irq_i && m_ie;
        trap     = irq_take || bad || is_ecall;

        operand = w.csr.funct3[2] ? {27'd0, w.csr.rs1_zimm} : rs1_data_i;
        old_val = model_read(w.csr.csr);
        case (w.csr.funct3[1:0])
            2'b01:   wval = operand;
            2'b10:   wval = old_val | operand;
            default: wval = old_val & ~operand;
        endcase

        n_ie    = m_ie;
        n_eie   = m_eie;
        n_mepc  = m_mepc;
        n_cause = m_cause;
        if (writes && !trap) begin
            case (w.csr.csr)
                csr_mstatus:  n_ie    = wval[0];
                csr_mestatus: n_eie   = wval[0];
                csr_mepc:     n_mepc  = wval;
                csr_mcause:   n_cause = {wval[31], wval[4:0]};
                default:      n_cause = m_cause;
            endcase
        end
        // trap entry with priority irq then illegal then ecall
        if (trap) begin
            n_cause = irq_take ? exp_irq_ext : (bad ? exp_illegal : exp_ecall);
            n_mepc  = pc_i;
            n_eie   = m_ie;
            n_ie    = 1'b0;
        end else if (is_mret) begin
            n_ie = m_eie;
        end

        exp_is_csr      = is_csr;
        exp_rd_data     = old_val;
        exp_rd_we       = is_csr && !trap && (w.csr.rd != 5'd0);
        exp_redirect    = trap || is_mret;
        exp_redirect_pc = trap ? trap_vector : m_mepc;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("Error %s: %s expected %h, got %h", test_name, sig, expv, actv);
        errors++;
    endtask

    ////////////////////
    // checking
    ////////////////////
    always @(posedge clk) begin
        if (!rst_n_i) begin
            m_ie    = 1'b0;
            m_eie   = 1'b0;
            m_mepc  = 32'd0;
            m_cause = 6'd0;
        end else begin
            compute_expect();
            checks++;
            assert (rd_we_o === exp_rd_we)
                else report_mismatch("rd_we_o", {31'd0, exp_rd_we}, {31'd0, rd_we_o});
            assert (redirect_o === exp_redirect)
                else report_mismatch("redirect_o", {31'd0, exp_redirect}, {31'd0, redirect_o});
            if (exp_redirect) begin
                assert (redirect_pc_o === exp_redirect_pc)
                    else report_mismatch("redirect_pc_o", exp_redirect_pc, redirect_pc_o);
            end
            if (exp_is_csr) begin
                assert (rd_data_o === exp_rd_data)
                    else report_mismatch("rd_data_o", exp_rd_data, rd_data_o);
            end
            m_ie    = n_ie;
            m_eie   = n_eie;
            m_mepc  = n_mepc;
            m_cause = n_cause;
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    function automatic sys_instr_u csr_word(input logic [2:0] f3, input csr_addr_t addr,
                                            input logic [4:0] src, input logic [4:0] rd);
        sys_instr_u w;

        w.csr.csr      = addr;
        w.csr.rs1_zimm = src;
        w.csr.funct3   = f3;
        w.csr.rd       = rd;
        w.csr.opcode   = opcode_system;
        return w;
    endfunction

    function automatic sys_instr_u priv_word(input logic [11:0] funct12);
        sys_instr_u w;

        w.priv.funct12 = funct12;
        w.priv.rs1     = 5'd0;
        w.priv.funct3  = 3'b000;
        w.priv.rd      = 5'd0;
        w.priv.opcode  = opcode_system;
        return w;
    endfunction

    task automatic issue(input sys_instr_u word, input logic [31:0] rs1, input logic irq_lvl);
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = word;
        rs1_data_i    = rs1;
        irq_i         = irq_lvl;
        pc_i          = $urandom & 32'hFFFF_FFFC;
    endtask

    task automatic idle(input logic irq_lvl);
        @(negedge clk);
        instr_valid_i = 1'b0;
        irq_i         = irq_lvl;
    endtask

    // csrrs with x0 source and x1 destination
    task automatic read_csr(input csr_addr_t addr, input logic irq_lvl);
        issue(csr_word(funct3_csrrs, addr, 5'd0, 5'd1), $urandom, irq_lvl);
    endtask

    // any csr funct3 except the privileged and reserved ones
    function automatic logic [2:0] pick_funct3();
        logic [2:0] f3;

        f3 = 3'($urandom_range(1, 6));
        if (f3 >= 3'd4) begin
            f3 = f3 + 3'd1;
        end
        return f3;
    endfunction

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        int          sel;
        logic        irq_lvl;
        csr_addr_t   addr;
        csr_addr_t   known_list [6];
        sys_instr_u  w;

        void'($urandom(69));
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        // lengths of the reset, ops, illegal, ecall/mret and irq tests
        cycle_limit = 2 * (12 + 64 + 32 + 12 + 180);
        known_list  = '{csr_mstatus, csr_mepc, csr_mcause, csr_mestatus,
                        csr_mcpuid, csr_mimpid};
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = 32'd0;
        rs1_data_i    = 32'd0;
        irq_i         = 1'b0;

        test_name = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        foreach (known_list[k]) begin
            read_csr(known_list[k], 1'b0);
        end

        test_name = "csr_ops";
        repeat (30) begin
            addr = known_list[$urandom_range(0, 3)];
            issue(csr_word(pick_funct3(), addr, 5'($urandom), 5'($urandom)), $urandom, 1'b0);
            read_csr(addr, 1'b0);
        end

        test_name = "illegal";
        issue(csr_word(funct3_csrrw, csr_mcpuid, 5'd3, 5'd2), $urandom, 1'b0);
        read_csr(csr_mcause, 1'b0);
        read_csr(csr_mepc, 1'b0);
        read_csr(csr_mcpuid, 1'b0);
        repeat (6) begin
            do begin
                addr = 12'($urandom);
            end while (addr_known(addr));
            issue(csr_word(pick_funct3(), addr, 5'($urandom), 5'd4), $urandom, 1'b0);
            read_csr(csr_mcause, 1'b0);
            read_csr(csr_mepc, 1'b0);
        end

        test_name = "ecall_mret";
        issue(csr_word(funct3_csrrsi, csr_mstatus, 5'd1, 5'd0), 32'd0, 1'b0);
        issue(priv_word(funct12_ecall), 32'd0, 1'b0);
        read_csr(csr_mestatus, 1'b0);
        read_csr(csr_mstatus, 1'b0);
        read_csr(csr_mcause, 1'b0);
        issue(priv_word(funct12_mret), 32'd0, 1'b0);
        read_csr(csr_mstatus, 1'b0);

        test_name = "irq_gate";
        issue(csr_word(funct3_csrrci, csr_mstatus, 5'd1, 5'd0), 32'd0, 1'b0);
        // irq pending but masked
        read_csr(csr_mepc, 1'b1);
        read_csr(csr_mcause, 1'b1);
        issue(csr_word(funct3_csrrw, csr_mepc, 5'd7, 5'd0), $urandom, 1'b1);
        read_csr(csr_mepc, 1'b1);
        issue(csr_word(funct3_csrrsi, csr_mstatus, 5'd1, 5'd0), 32'd0, 1'b1);
        // this one is replaced by the interrupt
        issue(csr_word(funct3_csrrw, csr_mepc, 5'd7, 5'd1), $urandom, 1'b1);
        read_csr(csr_mcause, 1'b0);
        read_csr(csr_mepc, 1'b0);
        read_csr(csr_mstatus, 1'b0);

        test_name = "random_mix";
        repeat (160) begin
            irq_lvl = ($urandom_range(0, 3) == 0);
            sel     = $urandom_range(0, 8);
            if (sel <= 3) begin
                w = csr_word(pick_funct3(), known_list[$urandom_range(0, 5)],
                             5'($urandom), 5'($urandom));
                issue(w, $urandom, irq_lvl);
            end else if (sel == 4) begin
                // fully random funct3 and address including reserved forms
                w = csr_word(3'($urandom), 12'($urandom), 5'($urandom), 5'($urandom));
                issue(w, $urandom, irq_lvl);
            end else if (sel == 5) begin
                issue(priv_word(funct12_ecall), 32'd0, irq_lvl);
            end else if (sel == 6) begin
                issue(priv_word(funct12_mret), 32'd0, irq_lvl);
            end else if (sel == 7) begin
                w = $urandom;
                w.csr.opcode = 7'h33;
                issue(w, $urandom, irq_lvl);
            end else begin
                idle(irq_lvl);
            end
        end

        idle(1'b0);
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
